// ==== include/net_macros.svh ====
`ifndef NET_MACROS_SVH
`define NET_MACROS_SVH

// Number of distinct point indices in the input stream
`define POINT_COUNT 64

// Upper bound on accepted pairs, which bounds how many network ids get allocated
`define CONN_COUNT 64

// How many of the largest network sizes are reported
`define TOP_COUNT 3

`endif

// ==== verilog/net_pkg.sv ====
`default_nettype none

`include "net_macros.svh"

package net_pkg;

    typedef logic [$clog2(`POINT_COUNT)-1:0] point_id_t;

    // Id 0 means "no network", so one more entry than the pair count is needed
    typedef logic [$clog2(`CONN_COUNT+1)-1:0] net_id_t;

    // A network can hold every point
    typedef logic [$clog2(`POINT_COUNT):0] net_size_t;

    typedef enum logic [2:0] {
        IGNORE,
        NEW,
        LOOKUP,
        JOIN_A,
        JOIN_B,
        MERGE,
        SAME
    } net_action_t;

    typedef enum logic [2:0] {
        IDLE,
        READ,
        CHASE,
        RESOLVE,
        SIZE_WR,
        SCAN,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== verilog/net_ctrl_fsm.sv ====
`default_nettype none

module net_ctrl_fsm import net_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire logic   pair_valid,
    input  net_id_t     lookup_a,
    input  net_id_t     lookup_b,
    input  net_id_t     final_a,
    input  net_id_t     final_b,
    input  wire logic   chase_done,
    input  wire logic   scan_done,
    output logic        pair_ready,
    output net_action_t action,
    output logic        chase_start,
    output logic        scan_en,
    output logic        sizes_final
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    // Set by the first accepted pair so an idle input before any pair is not taken as the end
    logic started;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            started <= 1'b0;
        end else begin
            state <= state_nxt;
            if (pair_valid && pair_ready) begin
                started <= 1'b1;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        action    = IGNORE;
        case (state)
            IDLE: begin
                if (pair_valid) begin
                    state_nxt = READ;
                end else if (started) begin
                    state_nxt = SCAN;
                end
            end
            READ: begin
                // Two unknown points open a network, two known ids need their chains chased
                if (lookup_a == '0 && lookup_b == '0) begin
                    action    = NEW;
                    state_nxt = IDLE;
                end else if (lookup_a == lookup_b) begin
                    action    = IGNORE;
                    state_nxt = IDLE;
                end else begin
                    action    = LOOKUP;
                    state_nxt = CHASE;
                end
            end
            CHASE: begin
                if (chase_done) begin
                    state_nxt = RESOLVE;
                end
            end
            RESOLVE: begin
                if ((final_a == '0) != (final_b == '0)) begin
                    action = (final_a == '0) ? JOIN_A : JOIN_B;
                end else if (final_a != final_b) begin
                    action = MERGE;
                end else begin
                    action = SAME;
                end
                state_nxt = SIZE_WR;
            end
            SIZE_WR: begin
                state_nxt = IDLE;
            end
            SCAN: begin
                if (scan_done) begin
                    state_nxt = DONE;
                end
            end
            default: begin
                state_nxt = DONE;
            end
        endcase
    end

    assign pair_ready  = (state == IDLE);
    assign chase_start = (action == LOOKUP);
    // Stop the address once it runs past the table so no read goes out of range
    assign scan_en     = (state == SCAN) && !scan_done;
    assign sizes_final = (state == DONE);

endmodule

`default_nettype wire

// ==== verilog/net_id_counter.sv ====
`default_nettype none

`include "net_macros.svh"

module net_id_counter import net_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  net_action_t action,
    input  wire logic   scan_en,
    output net_id_t     new_id,
    output net_id_t     scan_addr,
    output logic        scan_done
);

    // Id 0 is reserved, so allocation starts at 1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            new_id <= net_id_t'(1);
        end else if (action == NEW || action == MERGE) begin
            new_id <= new_id + net_id_t'(1);
        end
    end

    // The scan covers every id that could have been allocated
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_addr <= net_id_t'(1);
        end else if (scan_en) begin
            scan_addr <= scan_addr + net_id_t'(1);
        end
    end

    assign scan_done = (scan_addr > net_id_t'(`CONN_COUNT));

endmodule

`default_nettype wire

// ==== verilog/point_net_table.sv ====
`default_nettype none

`include "net_macros.svh"

module point_net_table import net_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  point_id_t   point_a,
    input  point_id_t   point_b,
    input  wire logic   pair_valid,
    input  wire logic   pair_ready,
    input  net_action_t action,
    input  net_id_t     new_id,
    input  net_id_t     final_a,
    input  net_id_t     final_b,
    output net_id_t     lookup_a,
    output net_id_t     lookup_b
);

    net_id_t   mem [`POINT_COUNT];
    point_id_t pair_a_r;
    point_id_t pair_b_r;
    logic      wr_a_en;
    logic      wr_b_en;
    net_id_t   wr_a_data;
    net_id_t   wr_b_data;

    // The accepted pair is kept for the writes that come once its networks are known
    always_ff @(posedge clk) begin
        if (pair_valid && pair_ready) begin
            pair_a_r <= point_a;
            pair_b_r <= point_b;
            lookup_a <= mem[point_a];
            lookup_b <= mem[point_b];
        end
    end

    // A joining point takes the id its partner resolved to
    assign wr_a_en   = (action == NEW) || (action == JOIN_A) || (action == MERGE);
    assign wr_b_en   = (action == NEW) || (action == JOIN_B) || (action == MERGE);
    assign wr_a_data = (action == JOIN_A) ? final_b : new_id;
    assign wr_b_data = (action == JOIN_B) ? final_a : new_id;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `POINT_COUNT; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (wr_a_en) begin
                mem[pair_a_r] <= wr_a_data;
            end
            if (wr_b_en) begin
                mem[pair_b_r] <= wr_b_data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/remap_table.sv ====
`default_nettype none

`include "net_macros.svh"

module remap_table import net_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire logic   chase_start,
    input  net_id_t     lookup_a,
    input  net_id_t     lookup_b,
    input  net_action_t action,
    input  net_id_t     new_id,
    output net_id_t     final_a,
    output net_id_t     final_b,
    output logic        chase_done
);

    // Each entry holds the id its network was merged into, 0 at the end of a chain
    net_id_t mem [`CONN_COUNT+1];

    // Index 0 follows point a, index 1 follows point b
    net_id_t start [2];
    net_id_t orig  [2];
    net_id_t cur   [2];
    net_id_t nxt   [2];
    logic    wen   [2];
    net_id_t waddr [2];
    net_id_t wdata [2];
    logic    resolved;

    assign start[0] = lookup_a;
    assign start[1] = lookup_b;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2; i++) begin
                orig[i] <= '0;
                cur[i]  <= '0;
                nxt[i]  <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (chase_start) begin
                    orig[i] <= start[i];
                    cur[i]  <= start[i];
                    nxt[i]  <= mem[start[i]];
                end else if (nxt[i] != '0) begin
                    // One link per cycle until the read returns the end marker
                    cur[i] <= nxt[i];
                    nxt[i] <= mem[nxt[i]];
                end
            end
        end
    end

    assign resolved = action inside {JOIN_A, JOIN_B, MERGE, SAME};

    // A merge retires both final ids under the fresh one
    // Otherwise the original ids are pointed straight at their ends to shorten later chases
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (action == MERGE) begin
                wen[i]   = 1'b1;
                waddr[i] = cur[i];
                wdata[i] = new_id;
            end else begin
                wen[i]   = resolved && (orig[i] != cur[i]);
                waddr[i] = orig[i];
                wdata[i] = cur[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i <= `CONN_COUNT; i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (wen[i]) begin
                    mem[waddr[i]] <= wdata[i];
                end
            end
        end
    end

    assign final_a    = cur[0];
    assign final_b    = cur[1];
    assign chase_done = (nxt[0] == '0) && (nxt[1] == '0);

endmodule

`default_nettype wire

// ==== verilog/size_table.sv ====
`default_nettype none

`include "net_macros.svh"

module size_table import net_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  net_action_t action,
    input  net_id_t     new_id,
    input  net_id_t     final_a,
    input  net_id_t     final_b,
    input  wire logic   scan_en,
    input  net_id_t     scan_addr,
    output net_size_t   scan_size,
    output logic        scan_valid
);

    net_size_t          mem [`CONN_COUNT+1];
    logic [`CONN_COUNT:0] valid;
    net_action_t        action_r;
    net_id_t            new_id_r;
    net_size_t          rd_a;
    net_size_t          rd_b;
    logic               wr_en;
    net_id_t            wr_addr;
    net_size_t          wr_data;

    // Sizes are read while resolving and written back one cycle later
    // Port b also serves the final scan
    always_ff @(posedge clk) begin
        new_id_r <= new_id;
        if (action inside {JOIN_A, JOIN_B, MERGE}) begin
            rd_a <= mem[final_a];
        end
        if (scan_en) begin
            rd_b <= mem[scan_addr];
        end else if (action inside {JOIN_A, JOIN_B, MERGE}) begin
            rd_b <= mem[final_b];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            action_r   <= IGNORE;
            scan_valid <= 1'b0;
        end else begin
            action_r   <= action;
            scan_valid <= scan_en && valid[scan_addr];
        end
    end

    // A new network always starts with its two points
    always_comb begin
        wr_en   = 1'b1;
        wr_addr = new_id;
        wr_data = net_size_t'(2);
        case (action_r)
            JOIN_A: begin
                wr_addr = final_b;
                wr_data = rd_b + net_size_t'(1);
            end
            JOIN_B: begin
                wr_addr = final_a;
                wr_data = rd_a + net_size_t'(1);
            end
            MERGE: begin
                wr_addr = new_id_r;
                wr_data = rd_a + rd_b;
            end
            default: begin
                wr_en = (action == NEW);
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Merged-away ids drop out of the scan
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else begin
            if (action == NEW) begin
                valid[new_id] <= 1'b1;
            end
            if (action_r == MERGE) begin
                valid[final_a]  <= 1'b0;
                valid[final_b]  <= 1'b0;
                valid[new_id_r] <= 1'b1;
            end
        end
    end

    assign scan_size = rd_b;

endmodule

`default_nettype wire

// ==== verilog/top_size_sorter.sv ====
`default_nettype none

`include "net_macros.svh"

module top_size_sorter import net_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  net_size_t  scan_size,
    input  wire logic  scan_valid,
    output net_size_t  net_sizes [`TOP_COUNT]
);

    // Slot 0 holds the largest size
    net_size_t             slot_nxt [`TOP_COUNT];
    logic [`TOP_COUNT-1:0] gt;

    // The slots stay in descending order, so gt is set from the insert point downwards
    always_comb begin
        for (int i = 0; i < `TOP_COUNT; i++) begin
            gt[i] = scan_size > net_sizes[i];
        end
        slot_nxt[0] = gt[0] ? scan_size : net_sizes[0];
        for (int i = 1; i < `TOP_COUNT; i++) begin
            if (gt[i-1]) begin
                slot_nxt[i] = net_sizes[i-1];
            end else if (gt[i]) begin
                slot_nxt[i] = scan_size;
            end else begin
                slot_nxt[i] = net_sizes[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `TOP_COUNT; i++) begin
            if (!rst_n) begin
                net_sizes[i] <= '0;
            end else if (scan_valid) begin
                net_sizes[i] <= slot_nxt[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/net_tracker.sv ====
`default_nettype none

`include "net_macros.svh"

module net_tracker import net_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  point_id_t  point_a,
    input  point_id_t  point_b,
    input  wire logic  pair_valid,
    output logic       pair_ready,
    output net_size_t  net_sizes [`TOP_COUNT],
    output logic       sizes_final
);

    net_action_t action;
    net_id_t     lookup_a;
    net_id_t     lookup_b;
    net_id_t     final_a;
    net_id_t     final_b;
    net_id_t     new_id;
    net_id_t     scan_addr;
    net_size_t   scan_size;
    logic        chase_start;
    logic        chase_done;
    logic        scan_en;
    logic        scan_done;
    logic        scan_valid;

    net_ctrl_fsm u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .pair_valid  (pair_valid),
        .lookup_a    (lookup_a),
        .lookup_b    (lookup_b),
        .final_a     (final_a),
        .final_b     (final_b),
        .chase_done  (chase_done),
        .scan_done   (scan_done),
        .pair_ready  (pair_ready),
        .action      (action),
        .chase_start (chase_start),
        .scan_en     (scan_en),
        .sizes_final (sizes_final)
    );

    net_id_counter u_id_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .action    (action),
        .scan_en   (scan_en),
        .new_id    (new_id),
        .scan_addr (scan_addr),
        .scan_done (scan_done)
    );

    point_net_table u_point_table (
        .clk        (clk),
        .rst_n      (rst_n),
        .point_a    (point_a),
        .point_b    (point_b),
        .pair_valid (pair_valid),
        .pair_ready (pair_ready),
        .action     (action),
        .new_id     (new_id),
        .final_a    (final_a),
        .final_b    (final_b),
        .lookup_a   (lookup_a),
        .lookup_b   (lookup_b)
    );

    remap_table u_remap_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .chase_start (chase_start),
        .lookup_a    (lookup_a),
        .lookup_b    (lookup_b),
        .action      (action),
        .new_id      (new_id),
        .final_a     (final_a),
        .final_b     (final_b),
        .chase_done  (chase_done)
    );

    size_table u_size_table (
        .clk        (clk),
        .rst_n      (rst_n),
        .action     (action),
        .new_id     (new_id),
        .final_a    (final_a),
        .final_b    (final_b),
        .scan_en    (scan_en),
        .scan_addr  (scan_addr),
        .scan_size  (scan_size),
        .scan_valid (scan_valid)
    );

    top_size_sorter u_sorter (
        .clk        (clk),
        .rst_n      (rst_n),
        .scan_size  (scan_size),
        .scan_valid (scan_valid),
        .net_sizes  (net_sizes)
    );

endmodule

`default_nettype wire

// ==== test/net_checker.sv ====
`default_nettype none

`include "net_macros.svh"

module net_checker import net_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic pair_valid,
    input  wire logic pair_ready,
    input  wire logic sizes_final,
    input  net_size_t net_sizes [`TOP_COUNT],
    input  point_id_t list_a [`CONN_COUNT],
    input  point_id_t list_b [`CONN_COUNT],
    input  int        pair_count,
    input  int        test_num,
    output int        tests_checked,
    output int        tests_failed
);

    timeunit 1ns;
    timeprecision 1ps;

    // Slot 0 holds the largest size, as in the DUT
    typedef net_size_t [`TOP_COUNT-1:0] size_list_t;

    logic       seen_accept;
    logic       busy_expected;
    logic       proto_err;
    logic       reported;
    logic       mismatch;
    size_list_t expected;
    string      exp_text;
    string      act_text;

    function automatic string test_label(input int num);
        case (num)
            0: return "two_pairs";
            1: return "disjoint_pairs";
            2: return "join_chain";
            3: return "merge_chains";
            4: return "repeated_pairs";
            5: return "random_pairs";
            default: return "unknown";
        endcase
    endfunction

    function automatic int root_of(input int parent [`POINT_COUNT], input int x);
        int r;
        r = x;
        while (parent[r] != r) begin
            r = parent[r];
        end
        return r;
    endfunction

    // Union-find over the pair list, then the largest group sizes padded with 0
    function automatic size_list_t reference_sizes(
        input point_id_t a_list [`CONN_COUNT],
        input point_id_t b_list [`CONN_COUNT],
        input int        count
    );
        int         parent  [`POINT_COUNT];
        int         members [`POINT_COUNT];
        logic       used    [`POINT_COUNT];
        int         ra;
        int         rb;
        int         best;
        size_list_t top;
        for (int i = 0; i < `POINT_COUNT; i++) begin
            parent[i]  = i;
            members[i] = 0;
            used[i]    = 1'b0;
        end
        for (int p = 0; p < count; p++) begin
            ra = root_of(parent, int'(a_list[p]));
            rb = root_of(parent, int'(b_list[p]));
            used[a_list[p]] = 1'b1;
            used[b_list[p]] = 1'b1;
            if (ra != rb) begin
                parent[ra] = rb;
            end
        end
        // Each point that took part counts once, under its root
        for (int i = 0; i < `POINT_COUNT; i++) begin
            if (used[i]) begin
                ra = root_of(parent, i);
                members[ra] = members[ra] + 1;
            end
        end
        top = '0;
        for (int k = 0; k < `TOP_COUNT; k++) begin
            best = 0;
            for (int i = 1; i < `POINT_COUNT; i++) begin
                if (members[i] > members[best]) begin
                    best = i;
                end
            end
            top[k] = net_size_t'(members[best]);
            members[best] = 0;
        end
        return top;
    endfunction

    task automatic report_test();
        expected = reference_sizes(list_a, list_b, pair_count);
        mismatch = 1'b0;
        exp_text = "";
        act_text = "";
        for (int k = 0; k < `TOP_COUNT; k++) begin
            if (net_sizes[k] != expected[k]) begin
                mismatch = 1'b1;
            end
            exp_text = {exp_text, $sformatf(" %0d", expected[k])};
            act_text = {act_text, $sformatf(" %0d", net_sizes[k])};
        end
        if (mismatch) begin
            $display("FAILED %s: expected%s, actual%s", test_label(test_num),
                     exp_text, act_text);
        end else if (proto_err) begin
            $display("Test %s: sizes are right but the handshake went wrong",
                     test_label(test_num));
        end else begin
            $display("Test %s: ok, sizes%s", test_label(test_num), act_text);
        end
        if (mismatch || proto_err) begin
            tests_failed = tests_failed + 1;
        end
        tests_checked = tests_checked + 1;
        reported      = 1'b1;
    endtask

    initial begin
        tests_checked = 0;
        tests_failed  = 0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            seen_accept   = 1'b0;
            busy_expected = 1'b0;
            proto_err     = 1'b0;
            reported      = 1'b0;
        end else begin
            // Only one pair is in flight, so ready has to drop after every accept
            if (busy_expected && pair_ready && !proto_err) begin
                $display("Test %s: pair_ready stayed high in the cycle after an accepted pair",
                         test_label(test_num));
                proto_err = 1'b1;
            end
            if (!seen_accept && (!pair_ready || sizes_final) && !proto_err) begin
                $display("Test %s: the DUT was not ready and idle after reset",
                         test_label(test_num));
                proto_err = 1'b1;
            end
            busy_expected = pair_valid && pair_ready;
            if (pair_valid && pair_ready) begin
                seen_accept = 1'b1;
            end
            if (sizes_final && !reported) begin
                report_test();
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_net_tracker.sv ====
`default_nettype none

`include "net_macros.svh"

module tb_net_tracker import net_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS   = 6;
    localparam int CLK_PERIOD  = 100;
    // Watchdog budget in cycles
    localparam int PAIR_BUDGET = 200;
    localparam int TEST_BUDGET = 100;

    logic        clk;
    logic        rst_n;
    point_id_t   point_a;
    point_id_t   point_b;
    logic        pair_valid;
    logic        pair_ready;
    net_size_t   net_sizes [`TOP_COUNT];
    logic        sizes_final;

    point_id_t   test_a [NUM_TESTS][`CONN_COUNT];
    point_id_t   test_b [NUM_TESTS][`CONN_COUNT];
    int          test_len [NUM_TESTS];
    point_id_t   list_a [`CONN_COUNT];
    point_id_t   list_b [`CONN_COUNT];
    int          pair_count;
    int          test_num;
    int          tests_checked;
    int          tests_failed;
    logic        tests_built;
    logic [31:0] rand_state;

    net_tracker UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .point_a     (point_a),
        .point_b     (point_b),
        .pair_valid  (pair_valid),
        .pair_ready  (pair_ready),
        .net_sizes   (net_sizes),
        .sizes_final (sizes_final)
    );

    net_checker u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .pair_valid    (pair_valid),
        .pair_ready    (pair_ready),
        .sizes_final   (sizes_final),
        .net_sizes     (net_sizes),
        .list_a        (list_a),
        .list_b        (list_b),
        .pair_count    (pair_count),
        .test_num      (test_num),
        .tests_checked (tests_checked),
        .tests_failed  (tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic add_pair(input int t, input int a, input int b);
        test_a[t][test_len[t]] = point_id_t'(a);
        test_b[t][test_len[t]] = point_id_t'(b);
        test_len[t] = test_len[t] + 1;
    endtask

    task automatic build_tests();
        int step;
        int a;
        int b;
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_len[t] = 0;
            for (int k = 0; k < `CONN_COUNT; k++) begin
                test_a[t][k] = '0;
                test_b[t][k] = '0;
            end
        end
        // Disjoint pairs, first fewer than the reported slots and then more
        add_pair(0, 0, 1);
        add_pair(0, 62, 63);
        for (int k = 0; k < 16; k++) begin
            add_pair(1, 2 * k + 1, 2 * k);
        end
        // One network grows a point at a time, joined from either side
        for (int k = 0; k < 20; k++) begin
            if (k % 2 == 0) begin
                add_pair(2, k, k + 1);
            end else begin
                add_pair(2, k + 1, k);
            end
        end
        add_pair(2, 40, 41);
        // Pairwise merges of ever larger networks leave remap chains four links deep
        for (int lvl = 0; lvl < 5; lvl++) begin
            step = 2 << lvl;
            for (int k = 0; k < 32 / step; k++) begin
                add_pair(3, k * step + step / 2 - 1, k * step + step / 2);
            end
        end
        add_pair(3, 0, 31);
        add_pair(3, 2, 29);
        add_pair(3, 33, 34);
        add_pair(3, 34, 35);
        // Pairs inside one network and pairs seen before
        add_pair(4, 0, 1);
        add_pair(4, 1, 2);
        add_pair(4, 0, 2);
        add_pair(4, 0, 1);
        add_pair(4, 1, 0);
        add_pair(4, 5, 6);
        add_pair(4, 6, 5);
        add_pair(4, 7, 8);
        add_pair(4, 5, 7);
        add_pair(4, 6, 8);
        add_pair(4, 8, 5);
        add_pair(4, 2, 0);
        for (int p = 0; p < 60; p++) begin
            a = 0;
            b = 0;
            while (a == b) begin
                rand_state = xorshift32(rand_state);
                a = int'(rand_state % `POINT_COUNT);
                rand_state = xorshift32(rand_state);
                b = int'(rand_state % `POINT_COUNT);
            end
            add_pair(5, a, b);
        end
    endtask

    task automatic load_test(input int t);
        for (int k = 0; k < `CONN_COUNT; k++) begin
            list_a[k] = test_a[t][k];
            list_b[k] = test_b[t][k];
        end
        pair_count = test_len[t];
        test_num   = t;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n      <= 1'b0;
        pair_valid <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        // One idle cycle lets the checker see the ready state before any pair
        @(posedge clk);
    endtask

    // Each pair is held until the DUT takes it, and valid stays high until the last one
    task automatic send_pairs();
        for (int p = 0; p < pair_count; p++) begin
            point_a    <= list_a[p];
            point_b    <= list_b[p];
            pair_valid <= 1'b1;
            @(posedge clk);
            while (!pair_ready) begin
                @(posedge clk);
            end
        end
        pair_valid <= 1'b0;
    endtask

    initial begin
        int total;
        wait (tests_built);
        total = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total = total + test_len[t];
        end
        #((total * PAIR_BUDGET + NUM_TESTS * TEST_BUDGET) * CLK_PERIOD);
        $display("Watchdog: test %0d did not report its sizes in time", test_num);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        pair_valid  = 1'b0;
        point_a     = '0;
        point_b     = '0;
        pair_count  = 0;
        test_num    = 0;
        tests_built = 1'b0;
        rand_state  = 32'd95674;
        for (int k = 0; k < `CONN_COUNT; k++) begin
            list_a[k] = '0;
            list_b[k] = '0;
        end
        build_tests();
        tests_built = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            load_test(t);
            apply_reset();
            send_pairs();
            wait (tests_checked == t + 1);
        end
        @(posedge clk);
        $display("Tests run: %0d, passed: %0d, failed: %0d", tests_checked,
                 tests_checked - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
verilog/net_pkg.sv
verilog/net_ctrl_fsm.sv
verilog/net_id_counter.sv
verilog/point_net_table.sv
verilog/remap_table.sv
verilog/size_table.sv
verilog/top_size_sorter.sv
verilog/net_tracker.sv
test/net_checker.sv
test/tb_net_tracker.sv

// ==== run.sh ====
#!/bin/sh
# Builds the network tracker testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_net_tracker \
    -f all.f \
    -o sim_net_tracker

output=$(./obj_dir/sim_net_tracker)
echo "$output"

# The run counts as passed only when the testbench printed its pass line
if echo "$output" | grep -qx "Simulation PASSED"; then
    exit 0
fi
echo "run.sh: the testbench reported a failure"
exit 1
